/* design/spwm_pkg.sv */
//==========================================================
// SPWM modulation constants, sine table, phase output struct
//==========================================================

package spwm_pkg;

    localparam int CARRIER_MAX = 16;                       // triangle peak, period 32 clk
    localparam int CARRIER_W   = $clog2(CARRIER_MAX + 1);
    localparam int SINE_STEPS  = 48;                       // one full sine period
    localparam int INDEX_W     = $clog2(SINE_STEPS);
    localparam int PHASE_SHIFT = 16;                       // 120 degrees

    // 8 + 8*sin(2*pi*k/48), rounded
    localparam logic [CARRIER_W-1:0] SINE_TABLE [SINE_STEPS] = '{
        5'd8,  5'd9,  5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd14,
        5'd15, 5'd15, 5'd16, 5'd16, 5'd16, 5'd16, 5'd16, 5'd15,
        5'd15, 5'd14, 5'd14, 5'd13, 5'd12, 5'd11, 5'd10, 5'd9,
        5'd8,  5'd7,  5'd6,  5'd5,  5'd4,  5'd3,  5'd2,  5'd2,
        5'd1,  5'd1,  5'd0,  5'd0,  5'd0,  5'd0,  5'd0,  5'd1,
        5'd1,  5'd2,  5'd2,  5'd3,  5'd4,  5'd5,  5'd6,  5'd7
    };

    typedef struct packed {
        logic phase_a;
        logic phase_b;
        logic phase_c;
        logic sync;     // start of sine period, one cycle
    } phase_out_t;

endpackage

/* design/link_pkg.sv */
//==========================================================
// UART timing, link commands, supervisor windows, link structs
//==========================================================

package link_pkg;

    // uart framing
    localparam int BIT_CYCLES = 8;                   // clk per bit
    localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);
    localparam int FRAME_BITS = 11;                  // start, 8 data, parity, stop

    // command codes, sent in this order
    localparam logic [7:0] CMD_TURN_ON  = 8'hEE;
    localparam logic [7:0] CMD_TURN_OFF = 8'h55;
    localparam logic [7:0] CMD_TOGGLE   = 8'hC3;

    // supervisor windows, scaled down for simulation
    localparam int STARTUP_CYCLES = 200;
    localparam int SEND_CYCLES    = 400;
    localparam int WAIT_CYCLES    = 300;
    localparam int CNT_W          = $clog2(SEND_CYCLES);   // widest window

    localparam logic LED_ON  = 1'b0;   // board leds are active low
    localparam logic LED_OFF = ~LED_ON;

    typedef struct packed {
        logic [7:0] data;
        logic       parity_error;
        logic       done;           // one-cycle strobe
    } rx_byte_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_t;

endpackage

/* design/uart_tx.sv */
//==========================================================
// UART transmitter, 8 data bits, even parity, one stop bit
//==========================================================
`timescale 1ns/1ns

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);
    import link_pkg::*;

    localparam int LEFT_W = $clog2(FRAME_BITS);

    logic [FRAME_BITS-2:0] shift_q;     // data, parity, stop still to go
    logic [LEFT_W-1:0]     bits_left;
    logic [BIT_CNT_W-1:0]  cyc_cnt;
    logic                  accept;
    logic                  bit_end;

    assign accept  = tx_start && !tx_busy;
    assign bit_end = tx_busy && (cyc_cnt == BIT_CNT_W'(BIT_CYCLES - 1));

    // line and bit timing
    always_ff @(posedge clk) begin
        if (reset) begin
            tx        <= 1'b1;          // idle high
            tx_busy   <= 1'b0;
            cyc_cnt   <= '0;
            bits_left <= '0;
        end else if (accept) begin
            tx        <= 1'b0;          // start bit
            tx_busy   <= 1'b1;
            cyc_cnt   <= '0;
            bits_left <= LEFT_W'(FRAME_BITS - 1);
        end else if (bit_end) begin
            cyc_cnt <= '0;
            if (bits_left == '0) begin
                tx_busy <= 1'b0;        // stop bit done
            end else begin
                tx        <= shift_q[0];
                bits_left <= bits_left - 1'b1;
            end
        end else if (tx_busy) begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // payload shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {1'b1, ^tx_data, tx_data};   // stop, even parity, data
        end else if (bit_end && bits_left != '0) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
        end
    end

endmodule

/* design/uart_rx.sv */
//==========================================================
// UART receiver with mid-bit sampling and even parity check
//==========================================================
`timescale 1ns/1ns

module uart_rx (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx,
    output link_pkg::rx_byte_t rx_out
);
    import link_pkg::*;

    localparam int SAMPLES = FRAME_BITS - 2;     // data bits plus parity
    localparam int IDX_W   = $clog2(SAMPLES + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_BITS
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [BIT_CNT_W-1:0] cyc_cnt;
    logic [IDX_W-1:0]     bit_idx;
    logic [SAMPLES-1:0]   shift_q;              // parity lands in the msb

    // two-flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    //==========================================================
    // frame FSM
    //==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RX_IDLE;
            cyc_cnt     <= '0;
            bit_idx     <= '0;
            rx_out.done <= 1'b0;
        end else begin
            rx_out.done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= RX_START;   // falling edge
                end
                RX_START: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (cyc_cnt == BIT_CNT_W'(BIT_CYCLES / 2 - 1)) begin
                        cyc_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_BITS;  // glitch dropped
                    end
                end
                RX_BITS: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (cyc_cnt == BIT_CNT_W'(BIT_CYCLES - 1)) begin
                        cyc_cnt <= '0;
                        if (bit_idx == IDX_W'(SAMPLES)) begin    // stop bit
                            rx_out.data         <= shift_q[7:0];
                            // a low stop bit is flagged as well
                            rx_out.parity_error <= (^shift_q) || !rx_sync;
                            rx_out.done         <= 1'b1;
                            state               <= RX_IDLE;
                        end else begin
                            shift_q <= {rx_sync, shift_q[SAMPLES-1:1]};
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* design/phase_generator.sv */
//==========================================================
// three-phase SPWM, triangle carrier against sine lookups
//==========================================================
`timescale 1ns/1ns

module phase_generator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold,
    output spwm_pkg::phase_out_t phases
);
    import spwm_pkg::*;

    logic [CARRIER_W-1:0] carrier;
    logic                 counting_down;
    logic [INDEX_W-1:0]   index;
    logic [INDEX_W-1:0]   index_b;
    logic [INDEX_W-1:0]   index_c;
    logic [CARRIER_W-1:0] level_a;
    logic [CARRIER_W-1:0] level_b;
    logic [CARRIER_W-1:0] level_c;
    logic                 stopped;

    assign stopped = reset || hold;

    //==========================================================
    // carrier and sine index
    //==========================================================
    always_ff @(posedge clk) begin
        if (stopped) begin
            carrier       <= '0;
            counting_down <= 1'b0;
            index         <= '0;
        end else if (!counting_down) begin
            carrier <= carrier + 1'b1;
            if (carrier == CARRIER_W'(CARRIER_MAX - 1)) begin
                counting_down <= 1'b1;                 // peak next
            end
        end else begin
            carrier <= carrier - 1'b1;
            if (carrier == CARRIER_W'(1)) begin
                counting_down <= 1'b0;                 // back at zero, new period
                if (index == INDEX_W'(SINE_STEPS - 1)) begin
                    index <= '0;
                end else begin
                    index <= index + 1'b1;
                end
            end
        end
    end

    // rotated indices, modulo SINE_STEPS
    always_comb begin
        if (index >= INDEX_W'(PHASE_SHIFT)) begin
            index_b = index - INDEX_W'(PHASE_SHIFT);
        end else begin
            index_b = index + INDEX_W'(SINE_STEPS - PHASE_SHIFT);
        end

        if (index >= INDEX_W'(2 * PHASE_SHIFT)) begin
            index_c = index - INDEX_W'(2 * PHASE_SHIFT);
        end else begin
            index_c = index + INDEX_W'(SINE_STEPS - 2 * PHASE_SHIFT);
        end
    end

    assign level_a = SINE_TABLE[index];
    assign level_b = SINE_TABLE[index_b];
    assign level_c = SINE_TABLE[index_c];

    //==========================================================
    // comparators and sync, registered
    //==========================================================
    always_ff @(posedge clk) begin
        if (stopped) begin
            phases <= '0;
        end else begin
            phases.phase_a <= level_a > carrier;
            phases.phase_b <= level_b > carrier;
            phases.phase_c <= level_c > carrier;
            // slaves realign their carriers on this
            phases.sync    <= (index == '0) && (carrier == '0);
        end
    end

endmodule

/* design/link_supervisor.sv */
//==========================================================
// link supervisor, startup hold, echo check and led status
//==========================================================
`timescale 1ns/1ns

module link_supervisor (
    input  logic               clk,
    input  logic               reset,
    input  link_pkg::rx_byte_t rx_in,
    input  logic               tx_busy,
    output logic [7:0]         tx_data,
    output logic               tx_start,
    output logic               hold,
    output link_pkg::led_t     leds
);
    import link_pkg::*;

    typedef enum logic [1:0] {
        INIT,
        SEND,
        WAIT
    } sup_state_t;

    sup_state_t       state;
    logic [CNT_W-1:0] counter;
    logic [1:0]       cmd_sel;       // rotation position
    logic             echo_ok;

    always_comb begin
        case (cmd_sel)
            2'd0:    tx_data = CMD_TURN_ON;
            2'd1:    tx_data = CMD_TURN_OFF;
            default: tx_data = CMD_TOGGLE;
        endcase
    end

    assign echo_ok = (rx_in.data == tx_data) && !rx_in.parity_error;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= INIT;
            counter  <= '0;
            cmd_sel  <= '0;
            tx_start <= 1'b0;
            hold     <= 1'b1;                              // modulator off
            leds     <= '{red: LED_OFF, green: LED_OFF, blue: LED_OFF};
        end else begin
            case (state)
                INIT: begin
                    counter <= counter + 1'b1;
                    if (counter == CNT_W'(STARTUP_CYCLES - 1)) begin
                        counter    <= '0;
                        hold       <= 1'b0;
                        leds.green <= LED_ON;              // board alive
                        state      <= SEND;
                    end
                end
                SEND: begin
                    tx_start <= 1'b1;
                    counter  <= counter + 1'b1;
                    if (counter == CNT_W'(SEND_CYCLES - 1)) begin
                        counter  <= '0;
                        tx_start <= 1'b0;
                        state    <= WAIT;
                    end
                end
                WAIT: begin
                    tx_start  <= 1'b0;
                    leds.blue <= LED_OFF;
                    if (!tx_busy) counter <= counter + 1'b1;   // window runs on idle line
                    if (!tx_busy && counter == CNT_W'(WAIT_CYCLES - 1)) begin
                        counter <= '0;
                        cmd_sel <= (cmd_sel == 2'd2) ? 2'd0 : cmd_sel + 1'b1;
                        state   <= SEND;
                    end
                end
                default: state <= INIT;
            endcase

            // echo compare, late echoes included
            if (rx_in.done && state != INIT) begin
                leds.red  <= echo_ok ? LED_ON : LED_OFF;
                leds.blue <= echo_ok ? LED_OFF : LED_ON;
            end
        end
    end

endmodule

/* design/spwm_master_top.sv */
//==========================================================
// master board top, UART link check and SPWM generator
//==========================================================
`timescale 1ns/1ns

module spwm_master_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx,
    output logic                 tx,
    output link_pkg::led_t       leds,
    output spwm_pkg::phase_out_t phases
);
    import link_pkg::*;

    rx_byte_t   rx_byte;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       hold;

    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .rx_out (rx_byte)
    );

    link_supervisor u_link_supervisor (
        .clk      (clk),
        .reset    (reset),
        .rx_in    (rx_byte),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .hold     (hold),
        .leds     (leds)
    );

    phase_generator u_phase_generator (
        .clk    (clk),
        .reset  (reset),
        .hold   (hold),     // released after startup
        .phases (phases)
    );

endmodule

/* sim/spwm_master_assertions.sv */
//==========================================================
// concurrent checks on supervisor and modulator signals
//==========================================================
`timescale 1ns/1ns

module spwm_master_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 hold,
    input logic                 tx_start,
    input link_pkg::led_t       leds,
    input spwm_pkg::phase_out_t phases
);
    import link_pkg::*;

    no_start_in_hold: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_start) |-> !hold)
        else $error("tx_start rose while hold was high");

    red_blue_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(leds.red == LED_ON && leds.blue == LED_ON))
        else $error("red and blue lit together");

    sync_one_cycle: assert property (@(posedge clk) disable iff (reset)
        phases.sync |=> !phases.sync)
        else $error("sync longer than one cycle");

    quiet_in_hold: assert property (@(posedge clk) disable iff (reset)
        hold |-> phases == '0)
        else $error("phase outputs active during hold");

endmodule

bind spwm_master_top spwm_master_assertions u_assertions (
    .clk      (clk),
    .reset    (reset),
    .hold     (hold),
    .tx_start (tx_start),
    .leds     (leds),
    .phases   (phases)
);

/* sim/spwm_master_tb.sv */
//==========================================================
// testbench for the SPWM master, echoing slave model and checks
//==========================================================
`timescale 1ns/1ns

module spwm_master_tb;
    import link_pkg::*;
    import spwm_pkg::*;

    localparam int WATCHDOG_CYCLES = STARTUP_CYCLES + 6 * (SEND_CYCLES + WAIT_CYCLES) + 2000;
    localparam int END_WINDOWS     = 5;
    localparam int SINE_PERIOD     = 1536;   // clk cycles per sine period

    logic       clk;
    logic       reset;
    logic       rx;
    logic       tx;
    led_t       leds;
    phase_out_t phases;

    int         errors = 0;
    int         cycle = 0;
    int         windows = 0;            // send windows seen, minus one
    int         frames = 0;
    int         last_frame_end = 0;
    int         echoes_checked = 0;
    int         last_echo_end = 0;
    int         idle_cycles = 0;
    int         mod_cycle = 0;
    int         sync_count = 0;
    int         last_sync = 0;
    int         a_high_cycles = 0;
    logic       echo_busy = 1'b0;
    logic [31:0] rng_state = 32'd13795;
    logic [7:0] echo_q[$];
    logic       hist_a[1024];           // phase_a history ring

    spwm_master_top DUT (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .tx     (tx),
        .leds   (leds),
        .phases (phases)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] command_for(input int window);
        case (window % 3)
            0:       return CMD_TURN_ON;
            1:       return CMD_TURN_OFF;
            default: return CMD_TOGGLE;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //==========================================================
    // slave model, tx frame decoder
    //==========================================================
    initial begin
        logic [9:0] bits;
        logic [7:0] expected;
        int         start_cycle;
        forever begin
            @(negedge clk);
            if (!reset && tx == 1'b0) begin
                start_cycle = cycle;
                repeat (BIT_CYCLES / 2) @(negedge clk);     // middle of start bit
                if (tx != 1'b0) begin
                    $display("Mismatch tx start bit expected 0 got %h", tx);
                    errors++;
                end
                for (int i = 0; i < 10; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    bits[i] = tx;
                end
                if (bits[8] != ^bits[7:0]) begin
                    $display("Mismatch parity for tx_data %h: expected %h got %h",
                             bits[7:0], ^bits[7:0], bits[8]);
                    errors++;
                end
                if (bits[9] != 1'b1) begin
                    $display("Mismatch stop bit for tx_data %h: expected 1 got %h",
                             bits[7:0], bits[9]);
                    errors++;
                end
                if (frames > 0 && start_cycle - last_frame_end > 50) windows++;   // long gap is WAIT
                expected = command_for(windows);
                if (bits[7:0] != expected) begin
                    $display("Mismatch tx_data expected %h got %h", expected, bits[7:0]);
                    errors++;
                end
                frames++;
                last_frame_end = cycle;
                echo_q.push_back(bits[7:0]);
            end
        end
    end

    //==========================================================
    // slave model, echo sender and led check
    //==========================================================
    initial begin
        logic [7:0]  data;
        logic        par;
        logic        corrupt;
        logic [10:0] frame;
        led_t        exp_leds;
        logic        seen;
        int          k;
        forever begin
            @(posedge clk);
            if (echo_q.size() > 0) begin
                data = echo_q.pop_front();
                rng_state = xorshift32(rng_state);
                repeat (rng_state[3:0] % 12) @(posedge clk);   // random gap
                echo_busy = 1'b1;
                par = ^data;
                corrupt = (rng_state[5:4] == 2'b00);
                if (corrupt && rng_state[6]) begin
                    data[rng_state[9:7]] = ~data[rng_state[9:7]];
                end else if (corrupt) begin
                    par = ~par;
                end
                frame = {1'b1, par, data, 1'b0};
                for (int i = 0; i < 10; i++) begin
                    rx <= frame[i];
                    repeat (BIT_CYCLES) @(posedge clk);
                end
                rx <= 1'b1;                                    // stop bit
                exp_leds.red   = corrupt ? LED_OFF : LED_ON;
                exp_leds.green = LED_ON;
                exp_leds.blue  = corrupt ? LED_ON : LED_OFF;
                seen = 1'b0;
                k = 0;
                while (!seen && k < 16) begin
                    @(negedge clk);
                    k++;
                    if (leds == exp_leds) seen = 1'b1;
                end
                if (!seen) begin
                    $display("Mismatch leds expected %h got %h", exp_leds, leds);
                    errors++;
                end
                if (k < BIT_CYCLES) repeat (BIT_CYCLES - k) @(posedge clk);
                echoes_checked++;
                last_echo_end = cycle;
                echo_busy = 1'b0;
            end
        end
    end

    // blue must be off once the line is quiet and no echo is pending
    always @(negedge clk) begin
        idle_cycles = (tx == 1'b1) ? idle_cycles + 1 : 0;
        if (!reset && !DUT.hold && idle_cycles >= 20 && !echo_busy && echo_q.size() == 0
            && cycle - last_echo_end >= 12 && leds.blue != LED_OFF) begin
            $display("Mismatch leds.blue expected %h got %h", LED_OFF, leds.blue);
            errors++;
        end
    end

    //==========================================================
    // phase relation and sync spacing
    //==========================================================
    always @(negedge clk) begin
        if (reset || DUT.hold) begin
            mod_cycle = 0;
        end else begin
            if (mod_cycle > 512 && phases.phase_b != hist_a[(mod_cycle - 512) % 1024]) begin
                $display("Mismatch phase_b expected %h got %h",
                         hist_a[(mod_cycle - 512) % 1024], phases.phase_b);
                errors++;
            end
            if (mod_cycle > 1024 && phases.phase_c != hist_a[mod_cycle % 1024]) begin
                $display("Mismatch phase_c expected %h got %h",
                         hist_a[mod_cycle % 1024], phases.phase_c);
                errors++;
            end
            hist_a[mod_cycle % 1024] = phases.phase_a;
            if (phases.sync) begin
                if (sync_count == 0 && mod_cycle > 3) begin
                    $display("first sync came too late after the modulator started");
                    errors++;
                end else if (sync_count > 0 && mod_cycle - last_sync != 1536) begin
                    $display("Mismatch sync spacing expected %h got %h",
                             1536, mod_cycle - last_sync);
                    errors++;
                end
                // sine around mid-carrier, so roughly half duty per period
                if (sync_count > 0 && (a_high_cycles < SINE_PERIOD * 3 / 8
                    || a_high_cycles > SINE_PERIOD * 5 / 8)) begin
                    $display("phase_a duty out of range, %0d high cycles in a sine period",
                             a_high_cycles);
                    errors++;
                end
                a_high_cycles = 0;
                last_sync = mod_cycle;
                sync_count++;
            end
            if (phases.phase_a) a_high_cycles++;
            mod_cycle++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not reach its end in %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    //==========================================================
    // main sequence
    //==========================================================
    initial begin
        reset = 1'b1;
        rx    = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < STARTUP_CYCLES - 1; i++) begin
            @(negedge clk);
            if (phases != '0 || leds != 3'b111 || tx != 1'b1) begin
                $display("Mismatch startup phases %h leds %h tx %h, expected 0 7 1",
                         phases, leds, tx);
                errors++;
            end
        end
        repeat (5) @(negedge clk);
        if (leds.green != LED_ON) begin
            $display("Mismatch leds.green expected %h got %h", LED_ON, leds.green);
            errors++;
        end
        while (windows < END_WINDOWS) @(posedge clk);
        while (echo_busy || echo_q.size() > 0) @(posedge clk);
        repeat (20) @(posedge clk);
        if (echoes_checked == 0 || sync_count < 2) begin
            $display("too little activity, %0d echoes and %0d syncs", echoes_checked,
                     sync_count);
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* spwm_master_top.f */
design/spwm_pkg.sv
design/link_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/phase_generator.sv
design/link_supervisor.sv
design/spwm_master_top.sv
sim/spwm_master_assertions.sv
sim/spwm_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SPWM master simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module spwm_master_tb \
    -f spwm_master_top.f \
    -o sim_spwm_master

./obj_dir/sim_spwm_master | tee /dev/stderr | grep "TEST PASS" > /dev/null

echo "simulation passed"
